/* include/mips_params.svh */
// memory depths, wishbone address map, opcode and funct codes
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define IMEM_WORDS 256
`define DMEM_WORDS 256

// bus regions, decoded on address bits 13:12
`define WB_IMEM 16'h0000
`define WB_REGS 16'h1000
`define WB_DMEM 16'h2000
`define WB_CTRL 16'h3000

`define OP_RTYPE 6'h00
`define OP_LW    6'h23
`define OP_SW    6'h2B
`define OP_BEQ   6'h04
`define OP_ADDI  6'h08
`define OP_HALT  6'h3F  // custom, stops fetch

`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2A

`endif

/* hw/mips_pkg.sv */
// word, instruction union, control word and pipeline register types
package mips_pkg;

	typedef logic [31:0] word_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} inst_r_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} inst_i_t;

	// one instruction word, two decodings
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_u;

	typedef struct packed {
		logic       halt;     // halt opcode marker
		logic       regdst;   // 1 = rd, 0 = rt
		logic       branch;
		logic       memread;
		logic       memtoreg;
		logic [1:0] aluop;    // 00 add, 01 sub, 10 funct
		logic       memwrite;
		logic       alusrc;   // 1 = immediate
		logic       regwrite;
	} ctrl_t;

	typedef struct packed {
		word_t pc_p4;
		inst_u inst;
		logic  valid;
	} if_id_t;

	typedef struct packed {
		word_t      pc_p4;
		word_t      data1;
		word_t      data2;
		word_t      seimm;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [5:0] funct;
		ctrl_t      ctrl;
		logic       valid;
	} id_ex_t;

	typedef struct packed {
		word_t      branch_target;
		word_t      alu_result;
		word_t      store_data;
		logic       zero;
		logic [4:0] wrreg;
		ctrl_t      ctrl;
		logic       valid;
	} ex_mem_t;

	// write-back path into the register file
	typedef struct packed {
		logic       regwrite;
		logic [4:0] wrreg;
		word_t      wrdata;
	} wb_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [15:0] adr;
		word_t       dat;
	} wb_req_t;

endpackage

/* hw/regm.sv */
// 32-entry register file, two pipeline read ports, debug read, one write
`timescale 1ns/1ps

module regm (
	input  logic            clk,
	input  logic [4:0]      read1,
	input  logic [4:0]      read2,
	input  logic [4:0]      dbg_reg,
	output mips_pkg::word_t data1,
	output mips_pkg::word_t data2,
	output mips_pkg::word_t dbg_data,
	input  mips_pkg::wb_t   wb
);
	import mips_pkg::*;

	word_t regs [32];

	// write-before-read with $0 hard-wired to zero
	function automatic word_t rd_port(input logic [4:0] idx);
		if (idx == 5'd0)
			return '0;
		else if (wb.regwrite && wb.wrreg == idx)
			return wb.wrdata;
		else
			return regs[idx];
	endfunction

	// reevaluated on any write-back or register change
	always_comb begin
		data1    = rd_port(read1);
		data2    = rd_port(read2);
		dbg_data = rd_port(dbg_reg);
	end

	always_ff @(posedge clk) begin
		if (wb.regwrite && wb.wrreg != 5'd0)
			regs[wb.wrreg] <= wb.wrdata;
	end

	// $0 stays zero even right after write-back targets it
	zero_reg: assert property (@(posedge clk)
		(wb.regwrite && wb.wrreg == 5'd0) |=>
			((read1 != 5'd0 || data1 == '0) && (dbg_reg != 5'd0 || dbg_data == '0)));

endmodule

/* hw/control.sv */
// wishbone slave, run/halt state and main opcode decoder
`timescale 1ns/1ps
`include "mips_params.svh"

module control (
	input  logic              clk,
	input  logic              rst,
	input  mips_pkg::wb_req_t wb_req,
	output mips_pkg::word_t   wb_dat,
	output logic              wb_ack,
	input  logic [5:0]        opcode,
	output mips_pkg::ctrl_t   ctrl,
	input  logic              halt_seen,
	output logic              run,
	output logic              start,
	output logic              imem_we,
	output logic [7:0]        mem_idx,
	output mips_pkg::word_t   mem_wdata,
	output logic              dmem_bus_we,
	input  mips_pkg::word_t   dmem_bus_rdata,
	output logic [4:0]        dbg_reg,
	input  mips_pkg::word_t   dbg_data
);
	import mips_pkg::*;

	localparam logic [15:0] imem_base = `WB_IMEM;
	localparam logic [15:0] regs_base = `WB_REGS;
	localparam logic [15:0] dmem_base = `WB_DMEM;
	localparam logic [15:0] ctrl_base = `WB_CTRL;

	logic       req;     // new transfer accepted this cycle
	logic       wr;
	logic [1:0] region;
	logic       halted;
	word_t      rd_data;

	assign req    = wb_req.cyc && wb_req.stb && !wb_ack;
	assign wr     = req && wb_req.we;
	assign region = wb_req.adr[13:12];

	assign mem_idx   = wb_req.adr[9:2];
	assign dbg_reg   = wb_req.adr[6:2];
	assign mem_wdata = wb_req.dat;

	// memory writes while running are acked but dropped
	assign imem_we     = wr && (region == imem_base[13:12]) && !run;
	assign dmem_bus_we = wr && (region == dmem_base[13:12]) && !run;
	assign start       = wr && (region == ctrl_base[13:12]) && wb_req.dat[0];

	always_comb begin
		case (region)
			regs_base[13:12]: rd_data = dbg_data;
			dmem_base[13:12]: rd_data = dmem_bus_rdata;
			ctrl_base[13:12]: rd_data = {30'd0, halted, run};
			default:          rd_data = '0;  // imem is write only
		endcase
	end

	always_ff @(posedge clk) begin
		if (req)
			wb_dat <= rd_data;
		if (rst) begin
			wb_ack <= 1'b0;
			run    <= 1'b0;
			halted <= 1'b0;
		end else begin
			wb_ack <= req;
			if (start) begin
				run    <= 1'b1;
				halted <= 1'b0;
			end else if (halt_seen) begin
				run    <= 1'b0;
				halted <= 1'b1;
			end
		end
	end

	// main decoder
	always_comb begin
		ctrl = '0;
		case (opcode)
			`OP_RTYPE: begin
				ctrl.regdst   = 1'b1;
				ctrl.aluop    = 2'b10;
				ctrl.regwrite = 1'b1;
			end
			`OP_LW: begin
				ctrl.memread  = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.regwrite = 1'b1;
			end
			`OP_SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			`OP_BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.aluop  = 2'b01;  // subtract for zero test
			end
			`OP_ADDI: begin
				ctrl.alusrc   = 1'b1;
				ctrl.regwrite = 1'b1;
			end
			`OP_HALT: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// one-cycle ack, the master must see it low before a new request
	ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

/* hw/stage1_if.sv */
// program counter, instruction memory and IF/ID register
`timescale 1ns/1ps
`include "mips_params.svh"

module stage1_if (
	input  logic             clk,
	input  logic             rst,
	input  logic             run,
	input  logic             start,
	input  logic             imem_we,
	input  logic [7:0]       mem_idx,
	input  mips_pkg::word_t  mem_wdata,
	input  logic             branch_taken,
	input  mips_pkg::word_t  branch_target,
	output mips_pkg::if_id_t if_id
);
	import mips_pkg::*;

	localparam int imem_aw = $clog2(`IMEM_WORDS);

	word_t imem [`IMEM_WORDS];
	word_t pc;
	word_t pc_p4;

	assign pc_p4 = pc + 32'd4;

	// bus load port, only used while halted
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[mem_idx] <= mem_wdata;
	end

	always_ff @(posedge clk) begin
		if (rst || start)
			pc <= '0;
		else if (run)
			pc <= branch_taken ? branch_target : pc_p4;
	end

	always_ff @(posedge clk) begin
		if_id.pc_p4 <= pc_p4;
		if_id.inst  <= imem[pc[imem_aw+1:2]];
		if (rst)
			if_id.valid <= 1'b0;
		else
			if_id.valid <= run;  // bubbles once stopped
	end

endmodule

/* hw/stage2_id.sv */
// instruction decode, sign extension, register read and ID/EX register
`timescale 1ns/1ps

module stage2_id (
	input  logic             clk,
	input  logic             rst,
	input  mips_pkg::if_id_t if_id,
	input  mips_pkg::ctrl_t  ctrl,
	output logic [5:0]       opcode,
	input  mips_pkg::wb_t    wb,
	input  logic [4:0]       dbg_reg,
	output mips_pkg::word_t  dbg_data,
	output mips_pkg::id_ex_t id_ex
);
	import mips_pkg::*;

	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [5:0]  funct;
	logic [15:0] imm;
	word_t       seimm;
	word_t       data1;
	word_t       data2;

	// R view for rd and funct, I view for the immediate
	assign opcode = if_id.inst.r.opcode;
	assign rs     = if_id.inst.i.rs;
	assign rt     = if_id.inst.i.rt;
	assign rd     = if_id.inst.r.rd;
	assign funct  = if_id.inst.r.funct;
	assign imm    = if_id.inst.i.imm;
	assign seimm  = {{16{imm[15]}}, imm};

	regm regs (
		.clk      (clk),
		.read1    (rs),
		.read2    (rt),
		.dbg_reg  (dbg_reg),
		.data1    (data1),
		.data2    (data2),
		.dbg_data (dbg_data),
		.wb       (wb)
	);

	always_ff @(posedge clk) begin
		id_ex.pc_p4 <= if_id.pc_p4;
		id_ex.data1 <= data1;
		id_ex.data2 <= data2;
		id_ex.seimm <= seimm;
		id_ex.rt    <= rt;
		id_ex.rd    <= rd;
		id_ex.funct <= funct;
		if (rst) begin
			id_ex.ctrl  <= '0;
			id_ex.valid <= 1'b0;
		end else begin
			id_ex.ctrl  <= if_id.valid ? ctrl : '0;  // bubble carries no control
			id_ex.valid <= if_id.valid;
		end
	end

endmodule

/* hw/stage3_ex.sv */
// ALU, branch target adder and EX/MEM register
`timescale 1ns/1ps
`include "mips_params.svh"

module stage3_ex (
	input  logic              clk,
	input  logic              rst,
	input  mips_pkg::id_ex_t  id_ex,
	output mips_pkg::ex_mem_t ex_mem
);
	import mips_pkg::*;

	word_t opb;
	word_t result;

	assign opb = id_ex.ctrl.alusrc ? id_ex.seimm : id_ex.data2;

	always_comb begin
		case (id_ex.ctrl.aluop)
			2'b00: result = id_ex.data1 + opb;  // lw, sw, addi
			2'b01: result = id_ex.data1 - opb;  // beq
			default: begin
				case (id_ex.funct)
					`FN_ADD: result = id_ex.data1 + opb;
					`FN_SUB: result = id_ex.data1 - opb;
					`FN_AND: result = id_ex.data1 & opb;
					`FN_OR:  result = id_ex.data1 | opb;
					`FN_SLT: result = {31'd0, $signed(id_ex.data1) < $signed(opb)};
					default: result = '0;
				endcase
			end
		endcase
	end

	always_ff @(posedge clk) begin
		ex_mem.branch_target <= id_ex.pc_p4 + {id_ex.seimm[29:0], 2'b00};
		ex_mem.alu_result    <= result;
		ex_mem.store_data    <= id_ex.data2;
		ex_mem.zero          <= (result == '0);
		ex_mem.wrreg         <= id_ex.ctrl.regdst ? id_ex.rd : id_ex.rt;
		if (rst) begin
			ex_mem.ctrl  <= '0;
			ex_mem.valid <= 1'b0;
		end else begin
			ex_mem.ctrl  <= id_ex.ctrl;
			ex_mem.valid <= id_ex.valid;
		end
	end

endmodule

/* hw/stage4_mem.sv */
// data memory, branch decision and write-back select
`timescale 1ns/1ps
`include "mips_params.svh"

module stage4_mem (
	input  logic              clk,
	input  mips_pkg::ex_mem_t ex_mem,
	input  logic              dmem_bus_we,
	input  logic [7:0]        mem_idx,
	input  mips_pkg::word_t   mem_wdata,
	output mips_pkg::word_t   dmem_bus_rdata,
	output logic              branch_taken,
	output mips_pkg::word_t   branch_target,
	output mips_pkg::wb_t     wb,
	output logic              halt_seen
);
	import mips_pkg::*;

	localparam int dmem_aw = $clog2(`DMEM_WORDS);

	word_t              dmem [`DMEM_WORDS];
	logic [dmem_aw-1:0] addr;
	logic               store;
	word_t              load_data;

	assign addr  = ex_mem.alu_result[dmem_aw+1:2];
	assign store = ex_mem.valid && ex_mem.ctrl.memwrite;

	// bus port writes only while halted, core port only while running
	always_ff @(posedge clk) begin
		if (dmem_bus_we)
			dmem[mem_idx] <= mem_wdata;
		if (store)
			dmem[addr] <= ex_mem.store_data;
	end

	assign load_data      = ex_mem.ctrl.memread ? dmem[addr] : '0;  // async read
	assign dmem_bus_rdata = dmem[mem_idx];

	assign branch_taken  = ex_mem.valid && ex_mem.ctrl.branch && ex_mem.zero;
	assign branch_target = ex_mem.branch_target;
	assign halt_seen     = ex_mem.valid && ex_mem.ctrl.halt;

	assign wb.regwrite = ex_mem.valid && ex_mem.ctrl.regwrite;
	assign wb.wrreg    = ex_mem.wrreg;
	assign wb.wrdata   = ex_mem.ctrl.memtoreg ? load_data : ex_mem.alu_result;

	// decoder never marks an instruction as both load and store
	no_rd_wr: assert property (@(posedge clk)
		ex_mem.valid |-> !(ex_mem.ctrl.memread && ex_mem.ctrl.memwrite));

endmodule

/* hw/mips_core.sv */
// top level, control plus the four pipeline stages
`timescale 1ns/1ps

module mips_core (
	input  logic              clk,
	input  logic              rst,
	input  mips_pkg::wb_req_t wb_req,
	output mips_pkg::word_t   wb_dat,
	output logic              wb_ack
);
	import mips_pkg::*;

	ctrl_t      ctrl;
	logic [5:0] opcode;
	logic       run;
	logic       start;
	logic       halt_seen;
	logic       imem_we;
	logic       dmem_bus_we;
	logic [7:0] mem_idx;
	word_t      mem_wdata;
	word_t      dmem_bus_rdata;
	logic [4:0] dbg_reg;
	word_t      dbg_data;
	logic       branch_taken;
	word_t      branch_target;
	if_id_t     if_id;
	id_ex_t     id_ex;
	ex_mem_t    ex_mem;
	wb_t        wb;

	control ctl (
		.clk            (clk),
		.rst            (rst),
		.wb_req         (wb_req),
		.wb_dat         (wb_dat),
		.wb_ack         (wb_ack),
		.opcode         (opcode),
		.ctrl           (ctrl),
		.halt_seen      (halt_seen),
		.run            (run),
		.start          (start),
		.imem_we        (imem_we),
		.mem_idx        (mem_idx),
		.mem_wdata      (mem_wdata),
		.dmem_bus_we    (dmem_bus_we),
		.dmem_bus_rdata (dmem_bus_rdata),
		.dbg_reg        (dbg_reg),
		.dbg_data       (dbg_data)
	);

	stage1_if s1 (
		.clk           (clk),
		.rst           (rst),
		.run           (run),
		.start         (start),
		.imem_we       (imem_we),
		.mem_idx       (mem_idx),
		.mem_wdata     (mem_wdata),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.if_id         (if_id)
	);

	stage2_id s2 (
		.clk      (clk),
		.rst      (rst),
		.if_id    (if_id),
		.ctrl     (ctrl),
		.opcode   (opcode),
		.wb       (wb),
		.dbg_reg  (dbg_reg),
		.dbg_data (dbg_data),
		.id_ex    (id_ex)
	);

	stage3_ex s3 (
		.clk    (clk),
		.rst    (rst),
		.id_ex  (id_ex),
		.ex_mem (ex_mem)
	);

	stage4_mem s4 (
		.clk            (clk),
		.ex_mem         (ex_mem),
		.dmem_bus_we    (dmem_bus_we),
		.mem_idx        (mem_idx),
		.mem_wdata      (mem_wdata),
		.dmem_bus_rdata (dmem_bus_rdata),
		.branch_taken   (branch_taken),
		.branch_target  (branch_target),
		.wb             (wb),
		.halt_seen      (halt_seen)
	);

endmodule

/* test/tb_mips_core.sv */
// testbench for mips_core, trace-driven bus stimulus, compare tasks and cycle timeout
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mips_core;
	import mips_pkg::*;

	localparam int          ack_limit  = 16;
	localparam int          poll_limit = 500;
	localparam logic [15:0] ctrl_adr   = `WB_CTRL;

	logic    clk;
	logic    rst;
	wb_req_t wb_req;
	word_t   wb_dat;
	logic    wb_ack;

	// one entry per trace command
	logic [7:0]  cmd_q  [$];
	logic [15:0] adr_q  [$];
	word_t       dat_q  [$];
	string       name_q [$];

	int limit  = 2000;  // raised once the trace length is known
	int cycles = 0;
	int errors = 0;
	int test_start_errors = 0;
	int checks = 0;
	int tests  = 0;
	int passed = 0;

	mips_core dut (
		.clk    (clk),
		.rst    (rst),
		.wb_req (wb_req),
		.wb_dat (wb_dat),
		.wb_ack (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles, the trace did not finish", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic load_trace(output bit ok);
		int               fd;
		int               n;
		logic [7:0]       cmd;
		logic [15:0]      adr;
		word_t            dat;
		logic [8*32-1:0]  name;
		logic [8*160-1:0] rest;
		fd = $fopen("test/prog_trace.txt", "r");
		ok = (fd != 0);
		if (!ok) begin
			$display("cannot open the trace file test/prog_trace.txt");
		end else begin
			while ($fscanf(fd, " %c", cmd) == 1) begin
				adr  = '0;
				dat  = '0;
				name = '0;
				if (cmd == "#") begin
					n = $fgets(rest, fd);  // comment line
				end else begin
					if (cmd == "W" || cmd == "R") begin
						n = $fscanf(fd, "%h %h", adr, dat);
						if (n != 2) begin
							$display("trace entry %0d: %c line lacks an address or a value",
								cmd_q.size(), cmd);
							ok = 1'b0;
						end
					end else if (cmd == "T") begin
						n = $fscanf(fd, "%s", name);
						if (n != 1) begin
							$display("trace entry %0d: T line lacks a test name",
								cmd_q.size());
							ok = 1'b0;
						end
					end
					cmd_q.push_back(cmd);
					adr_q.push_back(adr);
					dat_q.push_back(dat);
					name_q.push_back(string'(name));
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_reset();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	endtask

	// one classic cycle with ack one clock after the request
	task automatic bus_access(input logic we, input logic [15:0] adr, input word_t wdat,
			output word_t rdat);
		wb_req_t req;
		int      waits;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.dat = wdat;
		@(posedge clk);
		wb_req <= req;
		waits = 0;
		@(negedge clk);
		while (!wb_ack && waits < ack_limit) begin
			waits++;
			@(negedge clk);
		end
		rdat = wb_dat;  // stable between edges
		if (!wb_ack) begin
			$display("no bus ack for address %h within %0d cycles", adr, ack_limit);
			errors++;
		end else if (waits != 1) begin
			$display("bus ack for address %h came after %0d cycles, not 1", adr, waits);
			errors++;
		end
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic check_word(input string sig, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_status(input logic [1:0] exp, input logic [1:0] act);
		checks++;
		if (act !== exp) begin
			$display("CHECK FAILED at %0t ns: ctrl status expected %b got %b",
				$time, exp, act);
			errors++;
		end
	endtask

	task automatic wait_halt();
		word_t rd;
		int    polls;
		polls = 0;
		rd    = '0;
		while (!rd[1] && polls < poll_limit) begin
			bus_access(1'b0, ctrl_adr, '0, rd);
			polls++;
		end
		if (!rd[1]) begin
			$display("core never reported halted after %0d polls", poll_limit);
			errors++;
		end
	endtask

	task automatic close_test(input string name);
		tests++;
		if (errors == test_start_errors) begin
			passed++;
			$display("test %s passed", name);
		end else begin
			$display("test %s FAILED with %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	task automatic run_trace();
		word_t rd;
		for (int i = 0; i < cmd_q.size(); i++) begin
			case (cmd_q[i])
				"W": bus_access(1'b1, adr_q[i], dat_q[i], rd);
				"R": begin
					bus_access(1'b0, adr_q[i], '0, rd);
					if (adr_q[i][13:12] == ctrl_adr[13:12])
						check_status(dat_q[i][1:0], rd[1:0]);
					else
						check_word($sformatf("wb_dat @%h", adr_q[i]), dat_q[i], rd);
				end
				"G": bus_access(1'b1, ctrl_adr, 32'd1, rd);  // clear pc and run
				"H": wait_halt();
				"T": close_test(name_q[i]);
				default: begin
					$display("unknown trace command %c at entry %0d", cmd_q[i], i);
					errors++;
				end
			endcase
		end
	endtask

	initial begin
		bit ok;
		rst    = 1'b1;
		wb_req = '0;
		load_trace(ok);
		if (ok) begin
			limit = 40 * cmd_q.size() + 2000;
			apply_reset();
			run_trace();
		end else begin
			errors++;
		end
		$display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
			tests, passed, tests - passed, checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* test/prog_trace.txt */
# cmd addr data : W bus write, R bus read and compare, G start core, H wait for halt
# T name : closes the current test, addresses and data are hex
R 3000 00000000
W 2040 a5a50001
W 2044 5a5a0002
R 2040 a5a50001
R 2044 5a5a0002
T bus_access
# program, one word per line from pc 0
W 0000 2001000c
W 0004 2002fffb
W 0008 00000000
W 000c 00221820
W 0010 00222022
W 0014 00222824
W 0018 00223025
W 001c 0041382a
W 0020 0022402a
W 0024 ac030010
W 0028 ac260014
W 002c 8c090010
W 0030 8c0a0020
W 0034 20000005
W 0038 10210004
W 003c 200b0001
W 0040 200c0002
W 0044 200d0003
W 0048 200b0063
W 004c 10220004
W 0050 200f0055
W 0054 00000000
W 0058 00000000
W 005c 20100066
W 0060 fc000000
W 0064 00000000
W 0068 00000000
W 006c 00000000
G
H
R 1004 0000000c
R 1008 fffffffb
R 100c 00000007
R 1010 00000011
R 1014 00000008
R 1018 ffffffff
R 101c 00000001
R 1020 00000000
T alu_program
R 2010 00000007
R 2020 ffffffff
R 1024 00000007
R 1028 ffffffff
R 1000 00000000
T loads_stores
R 102c 00000001
R 1030 00000002
R 1034 00000003
R 103c 00000055
R 1040 00000066
T branch
R 3000 00000002
W 2010 00000000
G
W 2040 deadbeef
H
R 3000 00000002
R 2040 a5a50001
R 2010 00000007
R 1024 00000007
R 102c 00000001
R 1040 00000066
T halt_restart

/* filelist.f */
+incdir+include
hw/mips_pkg.sv
hw/regm.sv
hw/control.sv
hw/stage1_if.sv
hw/stage2_id.sv
hw/stage3_ex.sv
hw/stage4_mem.sv
hw/mips_core.sv
test/tb_mips_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project root"
	exit 1
fi

verilator --binary --assert --timescale 1ns/1ps --top-module tb_mips_core \
	-f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF "Test completed successfully"; then
	exit 0
fi
exit 1
